// File: design/board_pkg.sv
// VGA 640x480 timing at one pixel per clk, 8x8 board of 32-pixel squares at top-left
`default_nettype none

package board_pkg;

    // ----------------------------------------------------------------------
    // Video timing in clk cycles and lines
    // ----------------------------------------------------------------------
    localparam int H_VISIBLE = 640;
    localparam int H_FRONT   = 16;
    localparam int H_SYNC    = 96;
    localparam int H_BACK    = 48;
    localparam int V_VISIBLE = 480;
    localparam int V_FRONT   = 10;
    localparam int V_SYNC    = 2;
    localparam int V_BACK    = 33;

    localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK; // 800 cycles per line
    localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK; // 525 lines per frame

    // ----------------------------------------------------------------------
    // Board geometry
    // ----------------------------------------------------------------------
    localparam int SQUARE_SHIFT = 5;   // 32 px squares
    localparam int BOARD_DIM    = 8;   // Squares per side
    localparam int PIECE_INSET  = 8;   // First piece offset inside square
    localparam int PIECE_SPAN   = 16;  // Piece covers offsets 8..23
    localparam int PIPE_DEPTH   = 2;   // Coordinates in to RGB out

    typedef logic [2:0] pos_t;    // Board row or column
    typedef logic [9:0] coord_t;  // Pixel row or column
    typedef logic [11:0] rgb_t;   // 4:4:4 color

    // Codes 5..7 unused, drawn as empty squares
    typedef enum logic [2:0] {
        EMPTY   = 3'd0,
        P1_MAN  = 3'd1,
        P1_KING = 3'd2,
        P2_MAN  = 3'd3,
        P2_KING = 3'd4
    } piece_t;

    // Palette
    localparam rgb_t COL_BACKGROUND = 12'h124;
    localparam rgb_t COL_LIGHT      = 12'hEDB;
    localparam rgb_t COL_DARK       = 12'h853;
    localparam rgb_t COL_P1_MAN     = 12'hD22;
    localparam rgb_t COL_P1_KING    = 12'hF9A;
    localparam rgb_t COL_P2_MAN     = 12'h22D;
    localparam rgb_t COL_P2_KING    = 12'h9CF;
    localparam rgb_t COL_CURSOR     = 12'hFF0;

endpackage

`default_nettype wire

// File: design/video_if.sv
// Sync and blanking from the timing generator, syncs active low, coordinates unregistered
`timescale 1ns/1ps
`default_nettype none

interface video_if
    import board_pkg::*;
();

    logic   hsync;     // Low for columns 656..751
    logic   vsync;     // Low for lines 490..491
    logic   video_on;  // Visible 640x480 area
    coord_t row;       // Current line
    coord_t col;       // Current pixel in line

    // Timing generator side
    modport src (output hsync, vsync, video_on, row, col);

    // Pixel pipeline side
    modport sink (input hsync, vsync, video_on, row, col);

endinterface

`default_nettype wire

// File: design/quad_decoder.sv
// One step per rising A edge, direction from B level, position wraps mod 8, no debounce
`timescale 1ns/1ps
`default_nettype none

module quad_decoder
    import board_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic enc_a,
    input  logic enc_b,
    output pos_t pos
);

    // ----------------------------------------------------------------------
    // Input synchronizers
    // ----------------------------------------------------------------------
    logic [1:0] a_sync;  // [1] is the safe copy
    logic [1:0] b_sync;
    logic       a_prev;  // Last synchronized A
    logic       a_rise;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a_sync <= '0;
            b_sync <= '0;
            a_prev <= 1'b0;
        end else begin
            a_sync <= {a_sync[0], enc_a};
            b_sync <= {b_sync[0], enc_b};
            a_prev <= a_sync[1];
        end
    end

    assign a_rise = a_sync[1] & ~a_prev;  // Edge seen in the second sync stage

    // ----------------------------------------------------------------------
    // Position counter
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pos <= '0;
        end else if (a_rise) begin
            if (b_sync[1])
                pos <= pos - pos_t'(1);  // B high, counter-clockwise
            else
                pos <= pos + pos_t'(1);  // B low, clockwise
        end
    end

    // A position change always traces back to an A edge one cycle earlier
    a_pos_needs_edge: assert property (
        @(posedge clk) disable iff (!rst_n)
        $changed(pos) |-> $past(a_rise)
    );

endmodule

`default_nettype wire

// File: design/video_timing.sv
// Free-running 800x525 counters from reset, syncs and video_on decoded combinationally
`timescale 1ns/1ps
`default_nettype none

module video_timing
    import board_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    video_if.src  vid
);

    // ----------------------------------------------------------------------
    // Decode points
    // ----------------------------------------------------------------------
    localparam coord_t H_LAST     = coord_t'(H_TOTAL - 1);
    localparam coord_t V_LAST     = coord_t'(V_TOTAL - 1);
    localparam coord_t H_SYNC_BEG = coord_t'(H_VISIBLE + H_FRONT);  // 656
    localparam coord_t H_SYNC_END = coord_t'(H_VISIBLE + H_FRONT + H_SYNC);  // 752
    localparam coord_t V_SYNC_BEG = coord_t'(V_VISIBLE + V_FRONT);  // 490
    localparam coord_t V_SYNC_END = coord_t'(V_VISIBLE + V_FRONT + V_SYNC);  // 492
    localparam coord_t H_VIS_END  = coord_t'(H_VISIBLE);
    localparam coord_t V_VIS_END  = coord_t'(V_VISIBLE);

    coord_t h_cnt;  // Pixel in line
    coord_t v_cnt;  // Line in frame

    // ----------------------------------------------------------------------
    // Counters
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_LAST) begin
            h_cnt <= '0;  // End of line
            if (v_cnt == V_LAST)
                v_cnt <= '0;  // End of frame
            else
                v_cnt <= v_cnt + coord_t'(1);
        end else begin
            h_cnt <= h_cnt + coord_t'(1);
        end
    end

    // ----------------------------------------------------------------------
    // Decode
    // ----------------------------------------------------------------------
    assign vid.col      = h_cnt;
    assign vid.row      = v_cnt;
    assign vid.hsync    = !((h_cnt >= H_SYNC_BEG) && (h_cnt < H_SYNC_END));  // Active low
    assign vid.vsync    = !((v_cnt >= V_SYNC_BEG) && (v_cnt < V_SYNC_END));
    assign vid.video_on = (h_cnt < H_VIS_END) && (v_cnt < V_VIS_END);

    // Column never leaves the line
    a_col_in_line: assert property (
        @(posedge clk) disable iff (!rst_n)
        vid.col < coord_t'(H_TOTAL)
    );

endmodule

`default_nettype wire

// File: design/board_state.sv
// 64-square piece store, ready only after the post-reset clear, reads registered one cycle
`timescale 1ns/1ps
`default_nettype none

module board_state
    import board_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   wr_valid,
    output logic   wr_ready,
    input  pos_t   wr_col,
    input  pos_t   wr_row,
    input  piece_t wr_piece,
    input  pos_t   rd_col,
    input  pos_t   rd_row,
    output piece_t rd_piece
);

    localparam int         SQUARES  = BOARD_DIM * BOARD_DIM;
    localparam logic [5:0] CLR_LAST = 6'(SQUARES - 1);

    piece_t     mem [SQUARES];  // Index is {row, col}
    logic [5:0] clr_addr;       // Clear sequencer pointer
    logic       clearing;
    logic       wr_fire;

    // ----------------------------------------------------------------------
    // Clear sequencer
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clearing <= 1'b1;  // Starts sweeping right out of reset
            clr_addr <= '0;
        end else if (clearing) begin
            clr_addr <= clr_addr + 6'd1;
            if (clr_addr == CLR_LAST)
                clearing <= 1'b0;  // 64th square done
        end
    end

    assign wr_ready = !clearing;           // Only back-pressure is the clear
    assign wr_fire  = wr_valid && wr_ready;

    // ----------------------------------------------------------------------
    // Memory
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (clearing)
            mem[clr_addr] <= EMPTY;
        else if (wr_fire)
            mem[{wr_row, wr_col}] <= wr_piece;  // Seen by reads from next cycle
        rd_piece <= mem[{rd_row, rd_col}];       // Registered read
    end

    // No host write lands during the sweep
    a_no_write_clearing: assert property (
        @(posedge clk) disable iff (!rst_n)
        clearing |-> !wr_fire
    );

    // Once open, the port stays open until the next reset
    a_ready_sticky: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_ready |=> wr_ready
    );

endmodule

`default_nettype wire

// File: design/pixel_pipe.sv
// Two-cycle pixel path, board read issued in stage 1, syncs delayed to line up with RGB
`timescale 1ns/1ps
`default_nettype none

module pixel_pipe
    import board_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    video_if.sink  vid,
    input  pos_t   cursor_col,
    input  pos_t   cursor_row,
    output pos_t   rd_col,
    output pos_t   rd_row,
    input  piece_t rd_piece,
    output rgb_t   rgb,
    output logic   hs,
    output logic   vs
);

    localparam coord_t     BOARD_PX = coord_t'(BOARD_DIM << SQUARE_SHIFT);  // 256
    localparam logic [4:0] OFF_LAST = 5'((1 << SQUARE_SHIFT) - 1);           // 31
    localparam logic [4:0] INSET_LO = 5'(PIECE_INSET);
    localparam logic [4:0] INSET_HI = 5'(PIECE_INSET + PIECE_SPAN - 1);

    // ----------------------------------------------------------------------
    // Stage 1: square address and flags
    // ----------------------------------------------------------------------
    logic       s1_on, s1_hs, s1_vs;
    logic       s1_in_board;
    logic       s1_parity;   // Odd c+r, dark square
    logic       s1_cursor;   // Cursor square
    logic [4:0] s1_off_x, s1_off_y;

    assign rd_col = vid.col[SQUARE_SHIFT +: $bits(pos_t)];
    assign rd_row = vid.row[SQUARE_SHIFT +: $bits(pos_t)];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_on <= 1'b0;
            s1_hs <= 1'b1;
            s1_vs <= 1'b1;
        end else begin
            s1_on <= vid.video_on;
            s1_hs <= vid.hsync;
            s1_vs <= vid.vsync;
        end
    end

    always_ff @(posedge clk) begin
        s1_in_board <= (vid.col < BOARD_PX) && (vid.row < BOARD_PX);
        s1_off_x    <= vid.col[SQUARE_SHIFT-1:0];
        s1_off_y    <= vid.row[SQUARE_SHIFT-1:0];
        s1_parity   <= rd_col[0] ^ rd_row[0];
        s1_cursor   <= (rd_col == cursor_col) && (rd_row == cursor_row);
    end

    // ----------------------------------------------------------------------
    // Stage 2: layer select, piece arrives with the stage 1 flags
    // ----------------------------------------------------------------------
    rgb_t piece_rgb;
    logic has_piece;
    logic on_border;
    logic in_inset;
    rgb_t pix;

    always_comb begin
        has_piece = 1'b1;
        case (rd_piece)
            P1_MAN:  piece_rgb = COL_P1_MAN;
            P1_KING: piece_rgb = COL_P1_KING;
            P2_MAN:  piece_rgb = COL_P2_MAN;
            P2_KING: piece_rgb = COL_P2_KING;
            default: begin  // EMPTY and unused codes
                piece_rgb = COL_BACKGROUND;
                has_piece = 1'b0;
            end
        endcase
    end

    assign on_border = (s1_off_x == '0) || (s1_off_x == OFF_LAST) ||
                       (s1_off_y == '0) || (s1_off_y == OFF_LAST);
    assign in_inset  = (s1_off_x >= INSET_LO) && (s1_off_x <= INSET_HI) &&
                       (s1_off_y >= INSET_LO) && (s1_off_y <= INSET_HI);

    always_comb begin
        if (!s1_on)
            pix = '0;                   // Blanking
        else if (!s1_in_board)
            pix = COL_BACKGROUND;
        else if (s1_cursor && on_border)
            pix = COL_CURSOR;           // Cursor frame on top
        else if (has_piece && in_inset)
            pix = piece_rgb;
        else
            pix = s1_parity ? COL_DARK : COL_LIGHT;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rgb <= '0;
            hs  <= 1'b1;
            vs  <= 1'b1;
        end else begin
            rgb <= pix;
            hs  <= s1_hs;  // Same cycle as its pixel
            vs  <= s1_vs;
        end
    end

    // Blanked input gives black output one stage later
    a_blank_black: assert property (
        @(posedge clk) disable iff (!rst_n)
        !s1_on |=> (rgb == '0)
    );

endmodule

`default_nettype wire

// File: design/checkers_display.sv
// Board display top, all outputs registered, host writes refused for 64 cycles after reset
`timescale 1ns/1ps
`default_nettype none

module checkers_display
    import board_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       enc1_a,      // Column encoder
    input  logic       enc1_b,
    input  logic       enc2_a,      // Row encoder
    input  logic       enc2_b,
    input  logic       wr_valid,
    output logic       wr_ready,
    input  pos_t       wr_col,
    input  pos_t       wr_row,
    input  logic [2:0] wr_piece,    // piece_t code
    output logic [3:0] vga_r,
    output logic [3:0] vga_g,
    output logic [3:0] vga_b,
    output logic       vga_hs,
    output logic       vga_vs,
    output pos_t       cursor_col,
    output pos_t       cursor_row
);

    video_if vid_bus ();

    pos_t   rd_col, rd_row;
    piece_t rd_piece;
    rgb_t   rgb;

    // ----------------------------------------------------------------------
    // Cursor encoders
    // ----------------------------------------------------------------------
    quad_decoder u_enc_col (.clk, .rst_n, .enc_a(enc1_a), .enc_b(enc1_b), .pos(cursor_col));
    quad_decoder u_enc_row (.clk, .rst_n, .enc_a(enc2_a), .enc_b(enc2_b), .pos(cursor_row));

    board_state u_board (
        .clk, .rst_n,
        .wr_valid, .wr_ready, .wr_col, .wr_row,
        .wr_piece (piece_t'(wr_piece)),
        .rd_col, .rd_row, .rd_piece
    );

    // ----------------------------------------------------------------------
    // Video path
    // ----------------------------------------------------------------------
    video_timing u_timing (.clk, .rst_n, .vid(vid_bus.src));

    pixel_pipe u_pipe (
        .clk, .rst_n,
        .vid        (vid_bus.sink),
        .cursor_col, .cursor_row,
        .rd_col, .rd_row, .rd_piece,
        .rgb,
        .hs         (vga_hs),
        .vs         (vga_vs)
    );

    assign vga_r = rgb[11:8];
    assign vga_g = rgb[7:4];
    assign vga_b = rgb[3:0];

endmodule

`default_nettype wire

// File: dv/tb_checkers_display.sv
// Needs a full frame lock on vsync before pixel checks, run takes about 1.23M cycles
`timescale 1ns/1ps
`default_nettype none

module tb_checkers_display;
    import board_pkg::*;

    localparam int FRAME          = H_TOTAL * V_TOTAL;      // 420000 cycles
    localparam int TIMEOUT_CYCLES = 3 * FRAME + 240_000;    // Three frames plus setup

    logic clk, rst_n, enc1_a, enc1_b, enc2_a, enc2_b, wr_valid, wr_ready;
    logic [2:0] wr_col, wr_row, wr_piece, cursor_col, cursor_row;
    logic [3:0] vga_r, vga_g, vga_b;
    logic vga_hs, vga_vs;

    logic [31:0] lfsr_state = 32'h22048a5c;
    logic [2:0]  model [64];       // Index r*8+c
    int model_col, model_row;
    int errors, sync_errs, tests_run, tests_bad, cycle_count;
    int x, y, ncyc, hs_low, vs_low, last_hs_fall, last_vs_fall, hs_falls, vs_falls, pix_prints;
    logic locked, prev_hs, prev_vs, scan_req, scanning, scan_done;

    checkers_display u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Stop on a hang
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("tests failed");
        $finish;
    end

    // Galois LFSR, one step per bit taken
    function automatic int unsigned rand_bits(input int n);
        int unsigned v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
            v = (v << 1) | lfsr_state[0];
        end
        return v;
    endfunction

    // Reference colour from the board drawing rules
    function automatic logic [11:0] expected_pixel(input int px, input int py);
        int c, r, ox, oy;
        logic [2:0] p;
        if (px >= H_VISIBLE || py >= V_VISIBLE) return 12'h000;  // Blanking
        if (px >= (BOARD_DIM << SQUARE_SHIFT) || py >= (BOARD_DIM << SQUARE_SHIFT))
            return COL_BACKGROUND;
        c  = px >> SQUARE_SHIFT;
        r  = py >> SQUARE_SHIFT;
        ox = px % 32;
        oy = py % 32;
        p  = model[r * 8 + c];
        if (c == model_col && r == model_row && (ox == 0 || ox == 31 || oy == 0 || oy == 31))
            return COL_CURSOR;
        if (ox >= PIECE_INSET && ox < PIECE_INSET + PIECE_SPAN &&
            oy >= PIECE_INSET && oy < PIECE_INSET + PIECE_SPAN) begin
            case (p)
                3'd1: return COL_P1_MAN;
                3'd2: return COL_P1_KING;
                3'd3: return COL_P2_MAN;
                3'd4: return COL_P2_KING;
                default: ;  // Empty or unused code
            endcase
        end
        return ((c + r) % 2 == 0) ? COL_LIGHT : COL_DARK;
    endfunction

    // ----------------------------------------------------------------------
    // Output monitor, sampled mid-cycle
    // ----------------------------------------------------------------------
    always @(negedge clk) begin
        ncyc++;
        if (locked) begin
            x = (x == H_TOTAL - 1) ? 0 : x + 1;
            if (x == 0) y = (y == V_TOTAL - 1) ? 0 : y + 1;
        end
        if (prev_hs && !vga_hs) begin  // Falling hsync is column 656
            if (locked && x != H_VISIBLE + H_FRONT) begin
                $display("FAILED at %0t: hsync fell at column %0d, expected %0d", $time, x,
                         H_VISIBLE + H_FRONT);
                sync_errs++;
            end
            if (hs_falls > 0 && ncyc - last_hs_fall != H_TOTAL) begin
                $display("FAILED at %0t: hsync period %0d", $time, ncyc - last_hs_fall);
                sync_errs++;
            end
            last_hs_fall = ncyc;
            hs_falls++;
        end
        if (prev_vs && !vga_vs) begin  // Falling vsync is line 490, column 0
            if (vs_falls > 0 && ncyc - last_vs_fall != FRAME) begin
                $display("FAILED at %0t: vsync period %0d", $time, ncyc - last_vs_fall);
                sync_errs++;
            end
            last_vs_fall = ncyc;
            vs_falls++;
            x = 0;
            y = V_VISIBLE + V_FRONT;
            locked = 1'b1;
        end
        if (!prev_hs && vga_hs && hs_falls > 0 && hs_low != H_SYNC) begin
            $display("FAILED at %0t: hsync low for %0d cycles", $time, hs_low);
            sync_errs++;
        end
        if (!prev_vs && vga_vs && vs_falls > 0 && vs_low != V_SYNC * H_TOTAL) begin
            $display("FAILED at %0t: vsync low for %0d cycles", $time, vs_low);
            sync_errs++;
        end
        hs_low  = vga_hs ? 0 : hs_low + 1;
        vs_low  = vga_vs ? 0 : vs_low + 1;
        prev_hs = vga_hs;
        prev_vs = vga_vs;
        if (scan_req && locked && x == 0 && y == 0) begin  // Frame start
            scan_req = 1'b0;
            scanning = 1'b1;
            pix_prints = 0;
        end
        if (scanning) begin
            if ({vga_r, vga_g, vga_b} != expected_pixel(x, y)) begin
                errors++;
                if (pix_prints < 8)
                    $display("FAILED at %0t: pixel (%0d,%0d) is %h, expected %h", $time, x, y,
                             {vga_r, vga_g, vga_b}, expected_pixel(x, y));
                pix_prints++;
            end
            if (x == H_VISIBLE - 1 && y == V_VISIBLE - 1) begin
                scanning  = 1'b0;
                scan_done = 1'b1;
            end
        end
    end

    task automatic report(input string name, input int errs_before);
        tests_run++;
        if (errors != errs_before) tests_bad++;
        $display("%s %s", (errors != errs_before) ? "FAIL" : "ok  ", name);
    endtask

    task automatic scan_frame();
        scan_done = 1'b0;
        scan_req  = 1'b1;
        while (!scan_done) @(posedge clk);
    endtask

    task automatic set_enc_a(input bit row_enc, input bit val);
        if (row_enc) enc2_a <= val;
        else         enc1_a <= val;
    endtask

    // One detent: B sets the direction, then a full A pulse
    task automatic encoder_step(input bit row_enc, input bit down);
        @(posedge clk);
        if (row_enc) enc2_b <= down;
        else         enc1_b <= down;
        repeat (4) @(posedge clk);
        set_enc_a(row_enc, 1'b1);
        repeat (4) @(posedge clk);
        set_enc_a(row_enc, 1'b0);
        repeat (4) @(posedge clk);
        if (row_enc) model_row = (model_row + (down ? 7 : 1)) % 8;
        else         model_col = (model_col + (down ? 7 : 1)) % 8;
        @(negedge clk);
        if (cursor_col != model_col || cursor_row != model_row) begin
            $display("FAILED at %0t: cursor (%0d,%0d), expected (%0d,%0d)", $time,
                     cursor_col, cursor_row, model_col, model_row);
            errors++;
        end
    endtask

    task automatic move_cursor(input int col, input int row);
        while (model_col != col) encoder_step(1'b0, 1'b0);
        while (model_row != row) encoder_step(1'b1, 1'b0);
    endtask

    // Valid held until ready, model updated at the accepting edge
    task automatic host_write(input int col, input int row, input logic [2:0] piece);
        bit ready;
        @(posedge clk);
        wr_valid <= 1'b1;
        wr_col   <= 3'(col);
        wr_row   <= 3'(row);
        wr_piece <= piece;
        do begin
            @(negedge clk);
            ready = wr_ready;
            @(posedge clk);
        end while (!ready);
        wr_valid <= 1'b0;
        model[row * 8 + col] = piece;
        repeat (rand_bits(2)) @(posedge clk);  // Random gap
    endtask

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------
    initial begin
        int e, n, c, r;
        {rst_n, enc1_a, enc1_b, enc2_a, enc2_b, wr_valid} = '0;
        {wr_col, wr_row, wr_piece} = '0;
        {errors, sync_errs, tests_run, tests_bad, ncyc, hs_low, vs_low} = '0;
        {x, y, hs_falls, vs_falls, last_hs_fall, last_vs_fall, model_col, model_row} = '0;
        {locked, scan_req, scanning, scan_done} = '0;
        {prev_hs, prev_vs} = 2'b11;
        foreach (model[i]) model[i] = 3'd0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // Reset and clear
        e = errors;
        @(negedge clk);
        if (wr_ready) begin
            $display("FAILED at %0t: wr_ready high right after reset", $time);
            errors++;
        end
        n = 0;
        while (!wr_ready && n < 70) begin
            @(negedge clk);
            n++;
        end
        if (!wr_ready) begin
            $display("wr_ready never rose within 70 cycles of reset");
            errors++;
        end else if (n != 64) begin
            $display("FAILED at %0t: wr_ready rose after %0d cycles, expected 64", $time, n);
            errors++;
        end
        repeat (20) begin
            @(negedge clk);
            if (!wr_ready) begin
                $display("FAILED at %0t: wr_ready dropped after the clear", $time);
                errors++;
            end
        end
        report("reset and clear", e);

        // Encoders, forced wraps first, then random steps
        e = errors;
        encoder_step(1'b0, 1'b1);
        encoder_step(1'b0, 1'b0);
        encoder_step(1'b1, 1'b1);
        encoder_step(1'b1, 1'b0);
        repeat (25) begin
            c = rand_bits(1);
            r = rand_bits(1);
            repeat (rand_bits(2) + 1) encoder_step(c[0], r[0]);
        end
        move_cursor(0, 0);
        report("encoders", e);

        e = errors;
        scan_frame();
        report("empty board", e);

        // Pieces and overlay
        e = errors;
        for (int i = 0; i < 40; i++) begin
            if (i % 5 == 4) begin
                host_write(c, r, 3'd0);  // Clear the last square written
            end else begin
                c = rand_bits(3);
                r = rand_bits(3);
                host_write(c, r, 3'(rand_bits(3)));
            end
        end
        move_cursor(rand_bits(3), rand_bits(3));
        host_write(model_col, model_row, 3'd2);  // King under the cursor frame
        scan_frame();
        report("pieces and overlay", e);

        // Sync timing, measured throughout by the monitor
        e = errors;
        if (sync_errs != 0 || hs_falls < 2 || vs_falls < 2) begin
            $display("Sync timing wrong or not seen: %0d errors, %0d vsync edges",
                     sync_errs, vs_falls);
            errors++;
        end
        report("sync timing", e);

        $display("Summary: %0d run, %0d bad, %0d checks wrong", tests_run, tests_bad, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: checkers_display.f
design/board_pkg.sv
design/video_if.sv
design/quad_decoder.sv
design/video_timing.sv
design/board_state.sv
design/pixel_pipe.sv
design/checkers_display.sv
dv/tb_checkers_display.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_checkers_display
FILELIST  = checkers_display.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
